// ==== verilog/matmul_consts.svh ====
//////////////////////////////////////////////////
// Size and schedule constants for the 4x4 systolic
// matrix multiplier, included by the package and RTL
//////////////////////////////////////////////////
`ifndef MATMUL_CONSTS_SVH
`define MATMUL_CONSTS_SVH

// Array geometry and data widths
`define MAT_MUL_SIZE 4
`define DWIDTH 8
`define AWIDTH 10
`define ADDR_STRIDE_WIDTH 8

// Pipeline depth of the multiply-accumulate in each PE
`define NUM_CYCLES_IN_MAC 1

// Address cycles per operand and systolic fill plus drain
`define FEED_CYCLES 4
`define CYCLES_FOR_MATMUL 10

// Width of the run cycle counter
`define CLK_CNT_WIDTH 8

`endif

// ==== verilog/matmul_pkg.sv ====
//////////////////////////////////////////////////
// Shared types of the systolic matrix multiplier
//////////////////////////////////////////////////
`include "matmul_consts.svh"

package matmul_pkg;

    //////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////

    // One matrix element
    typedef logic [`DWIDTH-1:0] data_t;

    // Memory address and address stride
    typedef logic [`AWIDTH-1:0] addr_t;
    typedef logic [`ADDR_STRIDE_WIDTH-1:0] stride_t;

    // Cycle counter of one multiplication run
    typedef logic [`CLK_CNT_WIDTH-1:0] clk_cnt_t;

    //////////////////////////////////////////////////
    // Lane bundles
    //////////////////////////////////////////////////

    // Four elements side by side, lane 0 in the low bits.
    // Used for memory words, skewed operands and C rows
    typedef struct packed {
        data_t [`MAT_MUL_SIZE-1:0] lane;
    } lane_vec_t;

    // Whole result matrix, row 0 in the low bits
    typedef struct packed {
        lane_vec_t [`MAT_MUL_SIZE-1:0] row;
    } c_matrix_t;

    // States of the write-back machine
    typedef enum logic [1:0] {
        idle,
        write_rows,
        finish
    } writer_state_t;

endpackage

// ==== verilog/operand_feeder.sv ====
//////////////////////////////////////////////////
// Fetches A columns and B rows from memory, skews the
// lanes for the mesh and pulses done at the fixed count
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "matmul_consts.svh"

module operand_feeder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_mat_mul,
    input  matmul_pkg::addr_t     address_mat_a,
    input  matmul_pkg::addr_t     address_mat_b,
    input  matmul_pkg::stride_t   address_stride_a,
    input  matmul_pkg::stride_t   address_stride_b,
    input  matmul_pkg::lane_vec_t a_data,
    input  matmul_pkg::lane_vec_t b_data,
    output matmul_pkg::addr_t     a_addr,
    output matmul_pkg::addr_t     b_addr,
    output matmul_pkg::lane_vec_t a_skew,
    output matmul_pkg::lane_vec_t b_skew,
    output logic                  done_mat_mul
);
    import matmul_pkg::*;

    // The counter runs one ahead of the cycle number, and memory
    // answers one cycle after the address, so word k is on the bus
    // while the counter reads k + 2
    localparam clk_cnt_t DONE_CNT   = `CYCLES_FOR_MATMUL + `NUM_CYCLES_IN_MAC;
    localparam clk_cnt_t FEED_FIRST = 2;
    localparam clk_cnt_t FEED_LAST  = FEED_FIRST + `FEED_CYCLES - 1;

    clk_cnt_t  clk_cnt;
    logic      feed_valid;
    lane_vec_t a_gated;
    lane_vec_t b_gated;

    //////////////////////////////////////////////////
    // Run counter and done pulse
    //////////////////////////////////////////////////

    // Counting stops just past the done count so done fires once per start
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            clk_cnt      <= '0;
            done_mat_mul <= 1'b0;
        end else begin
            done_mat_mul <= (clk_cnt == DONE_CNT);
            if (clk_cnt <= DONE_CNT) begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Address generators
    //////////////////////////////////////////////////

    // Base on the first cycle, then one stride per cycle, then hold
    always_ff @(posedge clk) begin
        if (reset) begin
            a_addr <= '0;
            b_addr <= '0;
        end else if (start_mat_mul && clk_cnt < `FEED_CYCLES) begin
            if (clk_cnt == '0) begin
                a_addr <= address_mat_a;
                b_addr <= address_mat_b;
            end else begin
                a_addr <= a_addr + addr_t'(address_stride_a);
                b_addr <= b_addr + addr_t'(address_stride_b);
            end
        end
    end

    //////////////////////////////////////////////////
    // Operand gating and lane skew
    //////////////////////////////////////////////////

    // Outside the fetch window the held address keeps returning data,
    // which must not reach the accumulators
    assign feed_valid = start_mat_mul && (clk_cnt >= FEED_FIRST) && (clk_cnt <= FEED_LAST);
    assign a_gated    = feed_valid ? a_data : '0;
    assign b_gated    = feed_valid ? b_data : '0;

    // Lane i passes through i registers
    for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign a_skew.lane[i] = a_gated.lane[i];
            assign b_skew.lane[i] = b_gated.lane[i];
        end else begin : g_delay
            data_t a_pipe [i];
            data_t b_pipe [i];

            always_ff @(posedge clk) begin
                a_pipe[0] <= a_gated.lane[i];
                b_pipe[0] <= b_gated.lane[i];
                for (int s = 1; s < i; s++) begin
                    a_pipe[s] <= a_pipe[s-1];
                    b_pipe[s] <= b_pipe[s-1];
                end
            end

            assign a_skew.lane[i] = a_pipe[i-1];
            assign b_skew.lane[i] = b_pipe[i-1];
        end
    end

    // A run produces a single done beat
    assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul);

endmodule

// ==== verilog/processing_element.sv ====
//////////////////////////////////////////////////
// One mesh cell: accumulates a*b and forwards the
// operands to its right and lower neighbours
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "matmul_consts.svh"

module processing_element (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_mat_mul,
    input  matmul_pkg::data_t in_a,
    input  matmul_pkg::data_t in_b,
    output matmul_pkg::data_t out_a,
    output matmul_pkg::data_t out_b,
    output matmul_pkg::data_t out_c
);
    import matmul_pkg::*;

    data_t product;
    data_t acc;

    // Only the low byte of the product can reach the wrapped sum
    assign product = in_a * in_b;
    assign out_c   = acc;

    // Sum wraps at the element width, the accumulator clears between runs
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            acc <= '0;
        end else begin
            acc <= acc + product;
        end
    end

    // One cycle per hop across the mesh
    always_ff @(posedge clk) begin
        if (reset) begin
            out_a <= '0;
            out_b <= '0;
        end else begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

endmodule

// ==== verilog/pe_array.sv ====
//////////////////////////////////////////////////
// 4x4 systolic mesh. A flows right, B flows down and
// every cell keeps its own element of C
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "matmul_consts.svh"

module pe_array (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_mat_mul,
    input  matmul_pkg::lane_vec_t a_skew,
    input  matmul_pkg::lane_vec_t b_skew,
    output matmul_pkg::c_matrix_t c_matrix
);
    import matmul_pkg::*;

    // a_link[i][j] enters cell (i,j) from the left and
    // b_link[i][j] enters it from above. The last column and
    // row of links are where the operand chains end
    data_t a_link [`MAT_MUL_SIZE][`MAT_MUL_SIZE+1];
    data_t b_link [`MAT_MUL_SIZE+1][`MAT_MUL_SIZE];

    //////////////////////////////////////////////////
    // Mesh edge inputs
    //////////////////////////////////////////////////

    for (genvar k = 0; k < `MAT_MUL_SIZE; k++) begin : g_edge
        // Row k takes A lane k, column k takes B lane k
        assign a_link[k][0] = a_skew.lane[k];
        assign b_link[0][k] = b_skew.lane[k];
    end

    //////////////////////////////////////////////////
    // Cells
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_row
        for (genvar j = 0; j < `MAT_MUL_SIZE; j++) begin : g_col
            processing_element u_pe (
                .clk           (clk),
                .reset         (reset),
                .start_mat_mul (start_mat_mul),
                .in_a          (a_link[i][j]),
                .in_b          (b_link[i][j]),
                .out_a         (a_link[i][j+1]),
                .out_b         (b_link[i+1][j]),
                .out_c         (c_matrix.row[i].lane[j])
            );
        end
    end

endmodule

// ==== verilog/result_writer.sv ====
//////////////////////////////////////////////////
// Captures C when done pulses and streams it out one
// row per cycle with its address
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "matmul_consts.svh"

module result_writer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  done_mat_mul,
    input  matmul_pkg::c_matrix_t c_matrix,
    input  matmul_pkg::addr_t     address_mat_c,
    input  matmul_pkg::stride_t   address_stride_c,
    output matmul_pkg::addr_t     c_addr,
    output matmul_pkg::lane_vec_t c_data_out,
    output logic                  c_data_available
);
    import matmul_pkg::*;

    localparam int ROW_W = $clog2(`MAT_MUL_SIZE);
    localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`MAT_MUL_SIZE - 1);

    writer_state_t    state;
    logic [ROW_W-1:0] row_idx;
    c_matrix_t        c_latched;

    //////////////////////////////////////////////////
    // Write-back FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            row_idx <= '0;
            c_addr  <= '0;
        end else begin
            case (state)
                idle: begin
                    if (done_mat_mul) begin
                        state   <= write_rows;
                        row_idx <= '0;
                        c_addr  <= address_mat_c;
                    end
                end
                write_rows: begin
                    if (row_idx == LAST_ROW) begin
                        state <= finish;
                    end else begin
                        row_idx <= row_idx + 1'b1;
                        c_addr  <= c_addr + addr_t'(address_stride_c);
                    end
                end
                // One quiet beat before the next result block
                finish: begin
                    state   <= idle;
                    row_idx <= '0;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Result capture and output rows
    //////////////////////////////////////////////////

    // The mesh keeps accumulating after done, so the
    // finished sums are frozen here
    always_ff @(posedge clk) begin
        if (state == idle && done_mat_mul) begin
            c_latched <= c_matrix;
        end
    end

    assign c_data_available = (state == write_rows);
    assign c_data_out       = c_latched.row[row_idx];

    // Exactly one row per matrix row, then the valid level drops
    assert property (@(posedge clk) disable iff (reset)
        $rose(c_data_available) |-> ##(`MAT_MUL_SIZE) !c_data_available);

endmodule

// ==== verilog/matmul_4x4_systolic.sv ====
//////////////////////////////////////////////////
// Top of the 4x4 systolic matrix multiplier: feeder,
// PE mesh and result writer
//////////////////////////////////////////////////
`timescale 1ns/1ns

module matmul_4x4_systolic (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_mat_mul,
    input  matmul_pkg::addr_t     address_mat_a,
    input  matmul_pkg::addr_t     address_mat_b,
    input  matmul_pkg::addr_t     address_mat_c,
    input  matmul_pkg::stride_t   address_stride_a,
    input  matmul_pkg::stride_t   address_stride_b,
    input  matmul_pkg::stride_t   address_stride_c,
    input  matmul_pkg::lane_vec_t a_data,
    input  matmul_pkg::lane_vec_t b_data,
    output logic                  done_mat_mul,
    output matmul_pkg::addr_t     a_addr,
    output matmul_pkg::addr_t     b_addr,
    output matmul_pkg::addr_t     c_addr,
    output matmul_pkg::lane_vec_t c_data_out,
    output logic                  c_data_available
);
    import matmul_pkg::*;

    lane_vec_t a_skew;
    lane_vec_t b_skew;
    c_matrix_t c_matrix;

    operand_feeder u_operand_feeder (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .a_data           (a_data),
        .b_data           (b_data),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .a_skew           (a_skew),
        .b_skew           (b_skew),
        .done_mat_mul     (done_mat_mul)
    );

    pe_array u_pe_array (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .a_skew        (a_skew),
        .b_skew        (b_skew),
        .c_matrix      (c_matrix)
    );

    result_writer u_result_writer (
        .clk              (clk),
        .reset            (reset),
        .done_mat_mul     (done_mat_mul),
        .c_matrix         (c_matrix),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .c_addr           (c_addr),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available)
    );

endmodule

// ==== test/matmul_mem_model.sv ====
//////////////////////////////////////////////////
// Testbench memory for A and B with one-cycle reads.
// A load pulse writes fresh random matrices and the reference C
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "matmul_consts.svh"

module matmul_mem_model (
    input  logic                  clk,
    input  logic                  load,
    input  matmul_pkg::addr_t     base_a,
    input  matmul_pkg::addr_t     base_b,
    input  matmul_pkg::stride_t   stride_a,
    input  matmul_pkg::stride_t   stride_b,
    input  matmul_pkg::addr_t     a_addr,
    input  matmul_pkg::addr_t     b_addr,
    output matmul_pkg::lane_vec_t a_data,
    output matmul_pkg::lane_vec_t b_data,
    output matmul_pkg::c_matrix_t c_ref
);
    import matmul_pkg::*;

    localparam int N     = `MAT_MUL_SIZE;
    localparam int DEPTH = 1 << `AWIDTH;

    lane_vec_t   a_mem [DEPTH];
    lane_vec_t   b_mem [DEPTH];
    lane_vec_t   a_word = '0;
    lane_vec_t   b_word = '0;
    logic [31:0] fill_state = 32'd1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Background word, every address bit shows up in it
    function automatic lane_vec_t fill_word(input addr_t addr, input logic [7:0] tag);
        lane_vec_t w;
        w = {addr[7:0] ^ tag, {6'h0, addr[9:8]} ^ tag, ~addr[7:0], addr[9:2]};
        return w;
    endfunction

    // Read port, data one cycle after the address
    always @(posedge clk) begin
        a_word <= a_mem[a_addr];
        b_word <= b_mem[b_addr];
    end

    assign a_data = a_word;
    assign b_data = b_word;

    //////////////////////////////////////////////////
    // Matrix load and reference product
    //////////////////////////////////////////////////

    always @(posedge clk) begin : load_block
        data_t     a_mat [N][N];
        data_t     b_mat [N][N];
        lane_vec_t word;
        data_t     sum;
        addr_t     addr;
        if (load) begin
            for (int w = 0; w < DEPTH; w++) begin
                addr = addr_t'(w);
                a_mem[addr] <= fill_word(addr, 8'h3c);
                b_mem[addr] <= fill_word(addr, 8'hc3);
            end
            for (int r = 0; r < N; r++) begin
                for (int k = 0; k < N; k++) begin
                    fill_state = xorshift32(fill_state);
                    a_mat[r][k] = fill_state[7:0];
                    b_mat[r][k] = fill_state[23:16];
                end
            end
            // Word k holds column k of A and row k of B
            for (int k = 0; k < N; k++) begin
                addr = base_a + addr_t'(stride_a) * addr_t'(k);
                for (int i = 0; i < N; i++) begin
                    word.lane[i] = a_mat[i][k];
                end
                a_mem[addr] <= word;
                addr = base_b + addr_t'(stride_b) * addr_t'(k);
                for (int j = 0; j < N; j++) begin
                    word.lane[j] = b_mat[k][j];
                end
                b_mem[addr] <= word;
            end
            // Sums wrap at 8 bits like the accumulators
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    sum = '0;
                    for (int k = 0; k < N; k++) begin
                        sum = sum + a_mat[i][k] * b_mat[k][j];
                    end
                    c_ref.row[i].lane[j] <= sum;
                end
            end
        end
    end

endmodule

// ==== test/tb_matmul_4x4_systolic.sv ====
//////////////////////////////////////////////////
// Testbench for the 4x4 systolic multiplier: random runs
// checked against the reference product of the memory model
//////////////////////////////////////////////////
`timescale 1ns/1ns
`include "matmul_consts.svh"

module tb_matmul_4x4_systolic;
    import matmul_pkg::*;

    localparam int CLK_HALF    = 5;
    localparam int NUM_RUNS    = 20;
    localparam int RUN_CYCLES  = 40;
    localparam int WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + 100) * 2 * CLK_HALF;
    localparam int DONE_CYCLE  = `CYCLES_FOR_MATMUL + `NUM_CYCLES_IN_MAC;
    localparam int N           = `MAT_MUL_SIZE;

    logic        clk;
    logic        reset;
    logic        start_mat_mul;
    addr_t       address_mat_a;
    addr_t       address_mat_b;
    addr_t       address_mat_c;
    stride_t     address_stride_a;
    stride_t     address_stride_b;
    stride_t     address_stride_c;
    lane_vec_t   a_data;
    lane_vec_t   b_data;
    logic        done_mat_mul;
    addr_t       a_addr;
    addr_t       b_addr;
    addr_t       c_addr;
    lane_vec_t   c_data_out;
    logic        c_data_available;
    logic        load;
    c_matrix_t   c_ref;
    logic [31:0] rng_state;
    int          errors;
    int          checks;

    matmul_4x4_systolic i_dut (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_mat_c    (address_mat_c),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .address_stride_c (address_stride_c),
        .a_data           (a_data),
        .b_data           (b_data),
        .done_mat_mul     (done_mat_mul),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .c_addr           (c_addr),
        .c_data_out       (c_data_out),
        .c_data_available (c_data_available)
    );

    matmul_mem_model u_mem (
        .clk      (clk),
        .load     (load),
        .base_a   (address_mat_a),
        .base_b   (address_mat_b),
        .stride_a (address_stride_a),
        .stride_b (address_stride_b),
        .a_addr   (a_addr),
        .b_addr   (b_addr),
        .a_data   (a_data),
        .b_data   (b_data),
        .c_ref    (c_ref)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // One multiplication with fresh operands
    //////////////////////////////////////////////////

    // Starts and ends on a falling edge. Cycle n is sampled on the
    // falling edge after the n-th rising edge that sees start high
    task automatic do_run(input int run);
        int         cycle;
        int         done_cycle;
        int         done_beats;
        int         rows;
        bit         finished;
        addr_t      exp_addr;
        logic [1:0] row_sel;
        rng_state = xorshift32(rng_state);
        address_mat_a = rng_state[9:0];
        address_mat_b = rng_state[19:10];
        address_mat_c = rng_state[29:20];
        rng_state = xorshift32(rng_state);
        // Nonzero strides keep the four words of an operand apart
        address_stride_a = (rng_state[7:0] % 8'd255) + 8'd1;
        address_stride_b = (rng_state[15:8] % 8'd255) + 8'd1;
        address_stride_c = (rng_state[23:16] % 8'd255) + 8'd1;
        load = 1'b1;
        @(negedge clk);
        load = 1'b0;
        start_mat_mul = 1'b1;

        cycle = 0;
        done_cycle = -1;
        done_beats = 0;
        rows = 0;
        finished = 1'b0;
        while (!finished && cycle < RUN_CYCLES) begin
            @(negedge clk);
            if (cycle < `FEED_CYCLES) begin
                exp_addr = address_mat_a + addr_t'(address_stride_a) * addr_t'(cycle);
                check_value("a_addr", 32'(a_addr), 32'(exp_addr));
                exp_addr = address_mat_b + addr_t'(address_stride_b) * addr_t'(cycle);
                check_value("b_addr", 32'(b_addr), 32'(exp_addr));
            end
            if (done_mat_mul) begin
                if (done_cycle < 0) begin
                    done_cycle = cycle;
                end
                done_beats++;
            end
            if (c_data_available) begin
                exp_addr = address_mat_c + addr_t'(address_stride_c) * addr_t'(rows);
                check_value("c_addr", 32'(c_addr), 32'(exp_addr));
                if (rows < N) begin
                    row_sel = rows[1:0];
                    check_value("c_data_out", 32'(c_data_out), 32'(c_ref.row[row_sel]));
                end
                rows++;
            end else if (rows > 0) begin
                finished = 1'b1;
            end
            cycle++;
        end

        if (!finished) begin
            errors++;
            $display("Run %0d: the write-back did not end within %0d cycles", run, RUN_CYCLES);
        end
        check_value("done_mat_mul cycle", 32'(done_cycle), 32'(DONE_CYCLE));
        check_value("done_mat_mul beats", 32'(done_beats), 32'd1);
        check_value("c_data_available beats", 32'(rows), 32'(N));

        // start low for a cycle clears the accumulators
        start_mat_mul = 1'b0;
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        start_mat_mul = 1'b0;
        load = 1'b0;
        address_mat_a = '0;
        address_mat_b = '0;
        address_mat_c = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;
        rng_state = 32'd1;
        errors = 0;
        checks = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value("done_mat_mul", 32'(done_mat_mul), 32'd0);
        check_value("c_data_available", 32'(c_data_available), 32'd0);

        for (int run = 0; run < NUM_RUNS; run++) begin
            do_run(run);
        end

        $display("Summary: %0d runs, %0d checks, %0d errors", NUM_RUNS, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the runs did not complete within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== matmul_4x4_systolic.f ====
+incdir+verilog
verilog/matmul_pkg.sv
verilog/operand_feeder.sv
verilog/processing_element.sv
verilog/pe_array.sv
verilog/result_writer.sv
verilog/matmul_4x4_systolic.sv
test/matmul_mem_model.sv
test/tb_matmul_4x4_systolic.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from its output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_matmul_4x4_systolic \
    -f matmul_4x4_systolic.f -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }
result=$(./obj_dir/Vtb_matmul_4x4_systolic 2>&1)
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx "TESTS PASSED" && exit 0 || exit 1
